// ==== div_unit.f ====
+incdir+logic
logic/div_pkg.sv
logic/div_prep.sv
logic/div_iter.sv
logic/div_fixup.sv
logic/div_unit.sv
tb/div_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the divide unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal --top-module div_unit_tb -f div_unit.f -Mdir obj_dir \
  > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "build failed"
  exit 1
fi

./obj_dir/Vdiv_unit_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "tests failed" sim.log; then
  exit 1
fi
exit 0

// ==== tb/div_unit_tb.sv ====
// ==================================================
// testbench for div_unit, one operation in flight at a time
// ==================================================
`timescale 1ns/1ps
`include "div_defines.svh"

module div_unit_tb;

  localparam int NUM_OPS = 360;
  localparam int TIMEOUT = NUM_OPS * 80 + 200; // cycles

  logic                 clk;
  logic                 rst_n;
  logic                 div_valid_i;
  div_pkg::div_op_e     div_type_i;
  logic [`DIV_XLEN-1:0] dividend_i;
  logic [`DIV_XLEN-1:0] divisor_i;
  logic                 result_ready_i;
  logic [`DIV_XLEN-1:0] result_o;
  logic                 div_stall_o;
  logic                 result_ok_o;

  logic [31:0]          seed = 32'h3577_6332;
  int                   cyc = 0;
  int                   n_pass = 0;
  int                   n_fail = 0;
  int                   last_pass = 0;
  int                   last_fail = 0;
  logic [63:0]          exp_q[$];   // expected results in issue order
  div_pkg::div_op_e     op_q[$];
  int                   lat_q[$];
  int                   e0_q[$];    // cycle of the accepting edge
  logic                 in_res = 1'b0;
  logic [63:0]          held = '0;
  div_pkg::div_op_e     held_op = div_pkg::op_div;

  div_unit div_unit_i (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= TIMEOUT) begin
      $display("timeout after %0d cycles, a result never arrived", cyc);
      $display("tests failed");
      $finish;
    end
  end

  // ==================================================
  // stimulus helpers and reference model
  // ==================================================
  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic logic word_op(div_pkg::div_op_e op);
    return op == div_pkg::op_divw || op == div_pkg::op_divuw ||
           op == div_pkg::op_remw || op == div_pkg::op_remuw;
  endfunction

  // zero divisor, or most negative over minus one for the signed ops
  function automatic logic expect_exc(div_pkg::div_op_e op, logic [63:0] a, logic [63:0] b);
    if (word_op(op)) begin
      return b[31:0] == 0 || ((op == div_pkg::op_divw || op == div_pkg::op_remw) &&
             a[31:0] == 32'h8000_0000 && b[31:0] == 32'hffff_ffff);
    end
    return b == 0 || ((op == div_pkg::op_div || op == div_pkg::op_rem) &&
           a == {1'b1, 63'd0} && b == '1);
  endfunction

  function automatic logic [63:0] ref_div(div_pkg::div_op_e op, logic [63:0] a, logic [63:0] b);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic signed [31:0] wa;
    logic signed [31:0] wb;
    logic [31:0]        w;
    logic [63:0]        r;
    sa = a;
    sb = b;
    wa = a[31:0];
    wb = b[31:0];
    w  = '0;
    r  = '0;
    case (op)
      div_pkg::op_div, div_pkg::op_rem: begin
        if (b == 0)
          r = (op == div_pkg::op_div) ? '1 : a;
        else if (expect_exc(op, a, b))
          r = (op == div_pkg::op_div) ? a : '0;
        else if (op == div_pkg::op_div)
          r = sa / sb; // truncates toward zero
        else
          r = sa % sb; // takes the dividend's sign
      end
      div_pkg::op_divw, div_pkg::op_remw: begin
        if (b[31:0] == 0)
          w = (op == div_pkg::op_divw) ? '1 : a[31:0];
        else if (expect_exc(op, a, b))
          w = (op == div_pkg::op_divw) ? a[31:0] : '0;
        else if (op == div_pkg::op_divw)
          w = wa / wb;
        else
          w = wa % wb;
      end
      div_pkg::op_divu:  r = (b == 0) ? '1 : a / b;
      div_pkg::op_remu:  r = (b == 0) ? a : a % b;
      div_pkg::op_divuw: w = (b[31:0] == 0) ? '1 : a[31:0] / b[31:0];
      div_pkg::op_remuw: w = (b[31:0] == 0) ? a[31:0] : a[31:0] % b[31:0];
      default:           r = '0;
    endcase
    if (word_op(op))
      r = {{32{w[31]}}, w}; // W results sign-extend bit 31
    return r;
  endfunction

  // ==================================================
  // checks and reporting
  // ==================================================
  task automatic check_result(div_pkg::div_op_e op, string name, logic [63:0] got,
                              logic [63:0] exp);
    if (got === exp) begin
      n_pass++;
    end else begin
      n_fail++;
      $display("Mismatch at %0t: %s for %s got %h expected %h", $time, name, op.name(),
               got, exp);
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    if (got === exp) begin
      n_pass++;
    end else begin
      n_fail++;
      $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_count(string name, int got, int exp);
    if (got == exp) begin
      n_pass++;
    end else begin
      n_fail++;
      $display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic report_test(string name);
    $display("test %s: %0d checks, %0d failed", name,
             n_pass + n_fail - last_pass - last_fail, n_fail - last_fail);
    last_pass = n_pass;
    last_fail = n_fail;
  endtask

  // compare process, samples at the falling edge where outputs are settled
  always @(negedge clk) begin
    if (!rst_n) begin
      if (result_ok_o && !in_res) begin
        if (exp_q.size() == 0) begin
          n_fail++;
          $display("Error at %0t: result_ok_o rose with no operation pending", $time);
        end else begin
          held_op = op_q.pop_front();
          check_result(held_op, "result_o", result_o, exp_q.pop_front());
          check_count("result_ok_o latency", cyc - e0_q.pop_front(), lat_q.pop_front());
        end
        in_res = 1'b1;
        held   = result_o;
      end else if (result_ok_o) begin
        check_result(held_op, "result_o while held", result_o, held);
      end else begin
        in_res = 1'b0;
        check_result(held_op, "result_o while idle", result_o, '0);
        if (exp_q.size() != 0)
          check_flag("div_stall_o while busy", div_stall_o, 1'b1);
      end
    end
  end

  // issue one op, wait for its result, then release after stall_cyc cycles
  task automatic run_op(div_pkg::div_op_e op, logic [63:0] a, logic [63:0] b, int stall_cyc,
                        bit poke);
    int lat;
    lat = expect_exc(op, a, b) ? 2 : (word_op(op) ? `DIV_HALF + 2 : `DIV_XLEN + 2);
    @(posedge clk);
    #5;
    div_valid_i = 1'b1;
    div_type_i  = op;
    dividend_i  = a;
    divisor_i   = b;
    @(negedge clk);
    check_flag("div_stall_o on accept", div_stall_o, 1'b1);
    @(posedge clk);
    #5;
    div_valid_i = 1'b0;
    exp_q.push_back(ref_div(op, a, b));
    op_q.push_back(op);
    lat_q.push_back(lat);
    e0_q.push_back(cyc);
    @(negedge clk);
    while (!result_ok_o)
      @(negedge clk);
    if (poke && stall_cyc == 0)
      stall_cyc = 1;
    repeat (stall_cyc) begin
      @(posedge clk);
      #5;
      div_valid_i = poke; // must be ignored while the result waits
      div_type_i  = div_pkg::op_div;
    end
    @(posedge clk);
    #5;
    check_flag("result_ok_o under back-pressure", result_ok_o, 1'b1);
    div_valid_i    = 1'b0;
    result_ready_i = 1'b1;
    @(posedge clk);
    #5;
    result_ready_i = 1'b0;
  endtask

  // ==================================================
  // test sequence
  // ==================================================
  initial begin
    div_pkg::div_op_e ops64[4];
    div_pkg::div_op_e opsw[4];
    div_pkg::div_op_e op;
    logic [63:0]      a;
    logic [63:0]      b;
    int               i;
    int               s;
    ops64 = '{div_pkg::op_div, div_pkg::op_divu, div_pkg::op_rem, div_pkg::op_remu};
    opsw  = '{div_pkg::op_divw, div_pkg::op_divuw, div_pkg::op_remw, div_pkg::op_remuw};
    rst_n          = 1'b1; // reset is active high
    div_valid_i    = 1'b0;
    div_type_i     = div_pkg::op_div;
    dividend_i     = '0;
    divisor_i      = '0;
    result_ready_i = 1'b0;
    repeat (4) @(posedge clk);
    #5;
    rst_n = 1'b0;
    @(negedge clk);
    check_flag("div_stall_o after reset", div_stall_o, 1'b0);
    check_flag("result_ok_o after reset", result_ok_o, 1'b0);
    report_test("reset");

    for (i = 0; i < 4; i++) begin
      for (s = 0; s < 4; s++) begin
        a = s[1] ? -64'h0123_4567_89ab_cdef : 64'h0123_4567_89ab_cdef;
        b = s[0] ? -64'h0000_0000_0012_3457 : 64'h0000_0000_0012_3457;
        run_op(ops64[i], a, b, 0, 1'b0);
      end
    end
    report_test("directed 64-bit signs");

    for (i = 0; i < 4; i++) begin
      for (s = 0; s < 4; s++) begin
        a = {next_rand(), s[1] ? -32'h0765_4321 : 32'h0765_4321}; // garbage upper half
        b = {next_rand(), s[0] ? -32'h0000_1234 : 32'h0000_1234};
        run_op(opsw[i], a, b, 0, 1'b0);
      end
    end
    report_test("word forms");

    for (i = 0; i < 8; i++) begin
      op = div_pkg::div_op_e'(8'h01 << i);
      a  = {next_rand(), next_rand()};
      b  = word_op(op) ? {next_rand(), 32'h0} : '0;
      run_op(op, a, b, 0, 1'b0);
      a  = word_op(op) ? {next_rand(), 32'h8000_0000} : {1'b1, 63'd0};
      b  = word_op(op) ? {next_rand(), 32'hffff_ffff} : '1;
      run_op(op, a, b, 0, 1'b0);
    end
    report_test("zero divisor and overflow");

    for (i = 0; i < 310; i++) begin
      op = div_pkg::div_op_e'(8'h01 << (next_rand() >> 29));
      a  = {next_rand(), next_rand()};
      s  = int'(next_rand() >> 29);
      case (s)
        0:       b = '0;
        1, 2:    b = 64'(next_rand() >> 28);  // small divisor
        3:       b = -64'(next_rand() >> 29); // small negative
        default: b = {next_rand(), next_rand()} >> (next_rand() >> 27);
      endcase
      run_op(op, a, b, int'(next_rand() >> 29), i >= 300);
      if (i == 299)
        report_test("random");
    end
    report_test("back-pressure");

    @(posedge clk);
    #5;
    div_valid_i = 1'b1;
    div_type_i  = div_pkg::div_op_e'(8'h03); // two bits set
    dividend_i  = 64'd100;
    divisor_i   = 64'd7;
    repeat (70) begin
      @(negedge clk);
      check_flag("result_ok_o on invalid op", result_ok_o, 1'b0);
      check_flag("div_stall_o on invalid op", div_stall_o, 1'b0);
    end
    @(posedge clk);
    #5;
    div_valid_i = 1'b0;
    run_op(div_pkg::op_remw, 64'hffff_ffff_ffff_ff9c, 64'd7, 0, 1'b0);
    report_test("invalid op code");

    $display("checks: %0d passed, %0d failed", n_pass, n_fail);
    if (n_fail == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

// ==== logic/div_unit.sv ====
// ==================================================
// integer divide unit for the M extension, one op at a time
// div_valid_i must stay high until the unit takes it
// ==================================================
`timescale 1ns/1ps
`include "div_defines.svh"

module div_unit (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 div_valid_i,
  input  div_pkg::div_op_e     div_type_i,
  input  logic [`DIV_XLEN-1:0] dividend_i,
  input  logic [`DIV_XLEN-1:0] divisor_i,
  input  logic                 result_ready_i,
  output logic [`DIV_XLEN-1:0] result_o,
  output logic                 div_stall_o,
  output logic                 result_ok_o
);

  logic              start;
  logic              busy;
  logic              done;
  logic              hold;
  div_pkg::div_job_t job;
  div_pkg::div_raw_t raw;

  div_prep div_prep_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .div_valid_i (div_valid_i),
    .div_type_i  (div_type_i),
    .dividend_i  (dividend_i),
    .divisor_i   (divisor_i),
    .busy_i      (busy),
    .hold_i      (hold),
    .start_o     (start),
    .job_o       (job),
    .div_stall_o (div_stall_o)
  );

  div_iter div_iter_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .start_i (start),
    .job_i   (job),
    .busy_o  (busy),
    .done_o  (done),
    .raw_o   (raw)
  );

  div_fixup div_fixup_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .done_i         (done),
    .raw_i          (raw),
    .result_ready_i (result_ready_i),
    .hold_o         (hold),
    .result_o       (result_o),
    .result_ok_o    (result_ok_o)
  );

endmodule

// ==== logic/div_fixup.sv ====
// ==================================================
// sign fix and result select, held until result_ready_i
// result_o reads 0 whenever result_ok_o is low
// ==================================================
`timescale 1ns/1ps
`include "div_defines.svh"

module div_fixup (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 done_i,
  input  div_pkg::div_raw_t    raw_i,
  input  logic                 result_ready_i,
  output logic                 hold_o,
  output logic [`DIV_XLEN-1:0] result_o,
  output logic                 result_ok_o
);

  logic [`DIV_XLEN-1:0] q_mag;
  logic [`DIV_XLEN-1:0] r_mag;
  logic [`DIV_XLEN-1:0] q_signed;
  logic [`DIV_XLEN-1:0] r_signed;
  logic [`DIV_XLEN-1:0] q_word;   // W quotient, sign-extended
  logic [`DIV_XLEN-1:0] r_word;   // W remainder, sign-extended
  logic [`DIV_XLEN-1:0] res_sel;
  logic [`DIV_XLEN-1:0] res_q;
  logic                 ok_q;

  // ==================================================
  // sign restore and select
  // ==================================================
  assign q_mag    = raw_i.acc.halves.quot;
  assign r_mag    = raw_i.acc.halves.rem;
  assign q_signed = raw_i.quot_neg ? -q_mag : q_mag;
  assign r_signed = raw_i.rem_neg ? -r_mag : r_mag;

  assign q_word = {{(`DIV_XLEN-`DIV_HALF){q_signed[`DIV_HALF-1]}},
                   q_signed[`DIV_HALF-1:0]};
  assign r_word = {{(`DIV_XLEN-`DIV_HALF){r_signed[`DIV_HALF-1]}},
                   r_signed[`DIV_HALF-1:0]};

  always_comb begin
    if (raw_i.exc) begin
      res_sel = raw_i.exc_val; // architectural value from prep
    end else begin
      case (raw_i.op)
        div_pkg::op_div,
        div_pkg::op_divu: begin
          res_sel = q_signed;
        end
        div_pkg::op_divuw,
        div_pkg::op_divw: begin
          res_sel = q_word;
        end
        div_pkg::op_rem,
        div_pkg::op_remu: begin
          res_sel = r_signed;
        end
        div_pkg::op_remuw,
        div_pkg::op_remw: begin
          res_sel = r_word;
        end
        default: begin
          res_sel = '0;
        end
      endcase
    end
  end

  // ==================================================
  // result hold
  // ==================================================
  always_ff @(posedge clk) begin
    if (rst_n) begin
      ok_q <= 1'b0;
    end else if (done_i) begin
      ok_q <= 1'b1;
    end else if (ok_q && result_ready_i) begin
      ok_q <= 1'b0; // released, falls on this edge
    end
  end

  always_ff @(posedge clk) begin
    if (done_i) begin
      res_q <= res_sel;
    end
  end

  assign hold_o      = ok_q;
  assign result_ok_o = ok_q;
  assign result_o    = ok_q ? res_q : '0;

endmodule

// ==== logic/div_iter.sv ====
// ==================================================
// restoring divider, one quotient bit per clock
// a job with exc set skips the subtract loop
// ==================================================
`timescale 1ns/1ps
`include "div_defines.svh"

module div_iter (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              start_i,
  input  div_pkg::div_job_t job_i,
  output logic              busy_o,
  output logic              done_o,
  output div_pkg::div_raw_t raw_o
);

  typedef enum logic [1:0] {
    st_idle,
    st_run,
    st_fin
  } iter_state_e;

  iter_state_e             state;
  logic [`DIV_CNT_W-1:0]   cnt_q;
  logic                    done_q;
  div_pkg::div_acc_u       acc_q;
  div_pkg::div_acc_u       acc_nxt;
  logic [`DIV_XLEN-1:0]    divisor_q;
  div_pkg::div_op_e        op_q;
  logic                    quot_neg_q;
  logic                    rem_neg_q;
  logic                    exc_q;
  logic [`DIV_XLEN-1:0]    exc_val_q;
  logic [`DIV_XLEN:0]      trial;  // extra msb is the borrow

  // ==================================================
  // one shift-subtract step
  // ==================================================
  always_comb begin
    trial   = {acc_q.halves.rem, acc_q.halves.quot[`DIV_XLEN-1]} - {1'b0, divisor_q};
    acc_nxt = acc_q;
    acc_nxt.raw = acc_q.raw << 1;
    if (!trial[`DIV_XLEN]) begin
      acc_nxt.halves.rem     = trial[`DIV_XLEN-1:0]; // keep difference
      acc_nxt.halves.quot[0] = 1'b1;
    end
  end

  // ==================================================
  // control
  // ==================================================
  always_ff @(posedge clk) begin
    if (rst_n) begin
      state  <= st_idle;
      cnt_q  <= '0;
      done_q <= 1'b0;
    end else begin
      done_q <= (state == st_fin); // pulse one cycle after finish
      case (state)
        st_idle: begin
          if (start_i) begin
            cnt_q <= job_i.cnt;
            state <= job_i.exc ? st_fin : st_run;
          end
        end
        st_run: begin
          cnt_q <= cnt_q - 1'b1;
          if (cnt_q == `DIV_CNT_W'(1)) begin
            state <= st_fin; // last quotient bit
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // payload, loaded on start and stepped while running
  always_ff @(posedge clk) begin
    if (state == st_idle && start_i) begin
      acc_q      <= job_i.acc;
      divisor_q  <= job_i.divisor;
      op_q       <= job_i.op;
      quot_neg_q <= job_i.quot_neg;
      rem_neg_q  <= job_i.rem_neg;
      exc_q      <= job_i.exc;
      exc_val_q  <= job_i.exc_val;
    end else if (state == st_run) begin
      acc_q <= acc_nxt;
    end
  end

  assign busy_o = (state != st_idle) | done_q; // until fixup takes over
  assign done_o = done_q;

  assign raw_o.op       = op_q;
  assign raw_o.acc      = acc_q;
  assign raw_o.quot_neg = quot_neg_q;
  assign raw_o.rem_neg  = rem_neg_q;
  assign raw_o.exc      = exc_q;
  assign raw_o.exc_val  = exc_val_q;

endmodule

// ==== logic/div_prep.sv ====
// ==================================================
// operand prep, accepts only when iterate and fixup are idle
// W forms look at the low 32 bits of both operands only
// ==================================================
`timescale 1ns/1ps
`include "div_defines.svh"

module div_prep (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 div_valid_i,
  input  div_pkg::div_op_e     div_type_i,
  input  logic [`DIV_XLEN-1:0] dividend_i,
  input  logic [`DIV_XLEN-1:0] divisor_i,
  input  logic                 busy_i,
  input  logic                 hold_i,
  output logic                 start_o,
  output div_pkg::div_job_t    job_o,
  output logic                 div_stall_o
);

  logic                 valid_op;
  logic                 is_signed;
  logic                 is_word;
  logic                 is_rem;
  logic [`DIV_XLEN-1:0] a_op;      // dividend at full width
  logic [`DIV_XLEN-1:0] b_op;      // divisor at full width
  logic                 neg_a;
  logic                 neg_b;
  logic [`DIV_XLEN-1:0] abs_a;
  logic [`DIV_XLEN-1:0] abs_b;
  logic [`DIV_XLEN-1:0] dvd_sext;  // low half sign-extended
  logic [`DIV_XLEN-1:0] most_neg;
  logic                 div_zero;
  logic                 div_ovf;
  logic                 stall_q;

  // ==================================================
  // op decode
  // ==================================================
  always_comb begin
    valid_op  = 1'b1;
    is_signed = 1'b0;
    is_word   = 1'b0;
    is_rem    = 1'b0;
    case (div_type_i)
      div_pkg::op_div: begin
        is_signed = 1'b1;
      end
      div_pkg::op_divu: begin
        is_signed = 1'b0; // plain unsigned 64
      end
      div_pkg::op_divuw: begin
        is_word = 1'b1;
      end
      div_pkg::op_divw: begin
        is_signed = 1'b1;
        is_word   = 1'b1;
      end
      div_pkg::op_rem: begin
        is_signed = 1'b1;
        is_rem    = 1'b1;
      end
      div_pkg::op_remu: begin
        is_rem = 1'b1;
      end
      div_pkg::op_remuw: begin
        is_word = 1'b1;
        is_rem  = 1'b1;
      end
      div_pkg::op_remw: begin
        is_signed = 1'b1;
        is_word   = 1'b1;
        is_rem    = 1'b1;
      end
      default: begin
        valid_op = 1'b0; // not one-hot, drop it
      end
    endcase
  end

  // ==================================================
  // operands, magnitudes and exceptions
  // ==================================================
  assign dvd_sext = {{(`DIV_XLEN-`DIV_HALF){dividend_i[`DIV_HALF-1]}},
                     dividend_i[`DIV_HALF-1:0]};

  // W forms extend by signedness, so a_op/b_op are the true operand values
  assign a_op = is_word ? {{(`DIV_XLEN-`DIV_HALF){is_signed & dividend_i[`DIV_HALF-1]}},
                           dividend_i[`DIV_HALF-1:0]}
                        : dividend_i;
  assign b_op = is_word ? {{(`DIV_XLEN-`DIV_HALF){is_signed & divisor_i[`DIV_HALF-1]}},
                           divisor_i[`DIV_HALF-1:0]}
                        : divisor_i;

  assign neg_a = is_signed & a_op[`DIV_XLEN-1];
  assign neg_b = is_signed & b_op[`DIV_XLEN-1];
  assign abs_a = neg_a ? -a_op : a_op;
  assign abs_b = neg_b ? -b_op : b_op;

  assign most_neg = is_word ? {{(`DIV_XLEN-`DIV_HALF+1){1'b1}}, {(`DIV_HALF-1){1'b0}}}
                            : {1'b1, {(`DIV_XLEN-1){1'b0}}};

  assign div_zero = (b_op == '0);
  assign div_ovf  = is_signed & (a_op == most_neg) & (&b_op);

  // ==================================================
  // job packing
  // ==================================================
  always_comb begin
    job_o.op              = div_type_i;
    job_o.acc.halves.rem  = '0;
    job_o.acc.halves.quot = is_word ? {abs_a[`DIV_HALF-1:0], {`DIV_HALF{1'b0}}}
                                    : abs_a; // left-aligned for W
    job_o.divisor         = abs_b;
    job_o.cnt             = is_word ? `DIV_CNT_W'(`DIV_HALF) : `DIV_CNT_W'(`DIV_XLEN);
    job_o.quot_neg        = neg_a ^ neg_b;
    job_o.rem_neg         = neg_a;
    job_o.exc             = div_zero | div_ovf;
    if (div_zero) begin
      job_o.exc_val = is_rem ? (is_word ? dvd_sext : dividend_i) : {`DIV_XLEN{1'b1}};
    end else if (div_ovf) begin
      job_o.exc_val = is_rem ? '0 : a_op; // a_op already sign-extended for W
    end else begin
      job_o.exc_val = '0;
    end
  end

  assign start_o = div_valid_i & valid_op & ~busy_i & ~hold_i;

  // covers the edge where the job is taken
  always_ff @(posedge clk) begin
    if (rst_n) begin
      stall_q <= 1'b0;
    end else begin
      stall_q <= start_o;
    end
  end

  assign div_stall_o = start_o | stall_q | busy_i;

endmodule

// ==== logic/div_pkg.sv ====
// ==================================================
// shared types of the divide unit
// accumulator layout is tied to a 64-bit register
// ==================================================
`include "div_defines.svh"

package div_pkg;

  typedef enum logic [7:0] {
    op_div   = `DIV_OP_DIV,
    op_divu  = `DIV_OP_DIVU,
    op_divuw = `DIV_OP_DIVUW,
    op_divw  = `DIV_OP_DIVW,
    op_rem   = `DIV_OP_REM,
    op_remu  = `DIV_OP_REMU,
    op_remuw = `DIV_OP_REMUW,
    op_remw  = `DIV_OP_REMW
  } div_op_e;

  typedef struct packed {
    logic [`DIV_XLEN-1:0] rem;  // partial remainder
    logic [`DIV_XLEN-1:0] quot; // dividend bits in, quotient bits out
  } div_halves_t;

  // one 128-bit word, shifted as a whole or read as two halves
  typedef union packed {
    logic [2*`DIV_XLEN-1:0] raw;
    div_halves_t            halves;
  } div_acc_u;

  typedef struct packed {
    div_op_e                op;
    div_acc_u               acc;     // dividend magnitude preloaded
    logic [`DIV_XLEN-1:0]   divisor; // divisor magnitude
    logic [`DIV_CNT_W-1:0]  cnt;     // quotient bits to produce
    logic                   quot_neg;
    logic                   rem_neg;
    logic                   exc;     // zero divisor or overflow
    logic [`DIV_XLEN-1:0]   exc_val;
  } div_job_t;

  typedef struct packed {
    div_op_e                op;
    div_acc_u               acc;
    logic                   quot_neg;
    logic                   rem_neg;
    logic                   exc;
    logic [`DIV_XLEN-1:0]   exc_val;
  } div_raw_t;

endpackage

// ==== logic/div_defines.svh ====
// ==================================================
// widths and one-hot op codes for the divide unit
// op code bit order is fixed by the decoder upstream
// ==================================================
`ifndef DIV_DEFINES_SVH
`define DIV_DEFINES_SVH

`define DIV_XLEN 64 // register width
`define DIV_HALF 32 // width of the W forms

// one-hot operation codes, msb first
`define DIV_OP_DIV   8'b1000_0000 // signed 64
`define DIV_OP_DIVU  8'b0100_0000 // unsigned 64
`define DIV_OP_DIVUW 8'b0010_0000 // unsigned 32
`define DIV_OP_DIVW  8'b0001_0000 // signed 32
`define DIV_OP_REM   8'b0000_1000 // signed 64
`define DIV_OP_REMU  8'b0000_0100 // unsigned 64
`define DIV_OP_REMUW 8'b0000_0010 // unsigned 32
`define DIV_OP_REMW  8'b0000_0001 // signed 32

// iteration counter, holds up to DIV_XLEN quotient bits
`define DIV_CNT_W 7

`endif
